// File: Bender.yml
package:
  name: cl_hello_world

sources:
  - hdl/ocl_pkg.sv
  - hdl/ocl_write_channel.sv
  - hdl/ocl_read_channel.sv
  - hdl/hello_regs.sv
  - hdl/tick_counter.sv
  - hdl/cl_hello_world.sv
  - target: test
    files:
      - testbench/tb_cl_hello_world.sv

// File: filelist.f
hdl/ocl_pkg.sv
hdl/ocl_write_channel.sv
hdl/ocl_read_channel.sv
hdl/hello_regs.sv
hdl/tick_counter.sv
hdl/cl_hello_world.sv
testbench/tb_cl_hello_world.sv

// File: hdl/cl_hello_world.sv
//------------------------------
// Hello world endpoint top
//------------------------------
module cl_hello_world (
  input  logic               clk_main_a0,
  input  logic               rst_main_n_sync,
  input  logic               awvalid,
  input  ocl_pkg::ocl_addr_t awaddr,
  output logic               awready,
  input  logic               wvalid,
  input  ocl_pkg::ocl_data_t wdata,
  output logic               wready,
  output logic               bvalid,
  output ocl_pkg::ocl_resp_e bresp,
  input  logic               bready,
  input  logic               arvalid,
  input  ocl_pkg::ocl_addr_t araddr,
  output logic               arready,
  output logic               rvalid,
  output ocl_pkg::ocl_data_t rdata,
  output ocl_pkg::ocl_resp_e rresp,
  input  logic               rready,
  input  logic [15:0]        status_vdip,
  output logic [15:0]        status_vled
);

  localparam int LED_W  = 16;
  localparam int CNT_W  = 16;
  localparam int TICK_W = 8;

  // Register file access
  logic               reg_wr_en;
  ocl_pkg::ocl_addr_t reg_wr_addr;
  ocl_pkg::ocl_data_t reg_wr_data;
  ocl_pkg::ocl_addr_t reg_rd_addr;
  ocl_pkg::ocl_data_t reg_rd_data;

  // Counter controls and status
  logic              cnt_enable;
  logic              cnt_oneshot;
  logic              cnt_clear;
  logic              cnt_load;
  logic [TICK_W-1:0] tick_value;
  logic [CNT_W-1:0]  load_value;
  logic [CNT_W-1:0]  watermark;
  logic [CNT_W-1:0]  count;
  logic              ge_watermark;

  ocl_write_channel u_wr (
    .clk_main_a0, .rst_main_n_sync, .awvalid, .awaddr, .awready, .wvalid, .wdata,
    .wready, .bvalid, .bresp, .bready, .reg_wr_en, .reg_wr_addr, .reg_wr_data
  );

  ocl_read_channel u_rd (
    .clk_main_a0, .rst_main_n_sync, .arvalid, .araddr, .arready, .rvalid, .rdata,
    .rresp, .rready, .reg_rd_addr, .reg_rd_data
  );

  hello_regs #(.LED_W(LED_W), .CNT_W(CNT_W), .TICK_W(TICK_W)) u_regs (
    .clk_main_a0, .rst_main_n_sync, .reg_wr_en, .reg_wr_addr, .reg_wr_data,
    .reg_rd_addr, .reg_rd_data, .status_vdip, .status_vled, .cnt_enable,
    .cnt_oneshot, .cnt_clear, .cnt_load, .tick_value, .load_value, .watermark,
    .count, .ge_watermark
  );

  tick_counter #(.CNT_W(CNT_W), .TICK_W(TICK_W)) u_cnt (
    .clk_main_a0, .rst_main_n_sync, .cnt_enable, .cnt_oneshot, .cnt_clear,
    .cnt_load, .tick_value, .load_value, .watermark, .count, .ge_watermark
  );

endmodule

// File: hdl/hello_regs.sv
//------------------------------
// Hello world register file
//------------------------------
module hello_regs #(
  parameter int LED_W  = 16,
  parameter int CNT_W  = 16,
  parameter int TICK_W = 8
) (
  input  logic               clk_main_a0,
  input  logic               rst_main_n_sync,
  input  logic               reg_wr_en,
  input  ocl_pkg::ocl_addr_t reg_wr_addr,
  input  ocl_pkg::ocl_data_t reg_wr_data,
  input  ocl_pkg::ocl_addr_t reg_rd_addr,
  output ocl_pkg::ocl_data_t reg_rd_data,
  input  logic [LED_W-1:0]   status_vdip,
  output logic [LED_W-1:0]   status_vled,
  output logic               cnt_enable,
  output logic               cnt_oneshot,
  output logic               cnt_clear,
  output logic               cnt_load,
  output logic [TICK_W-1:0]  tick_value,
  output logic [CNT_W-1:0]   load_value,
  output logic [CNT_W-1:0]   watermark,
  input  logic [CNT_W-1:0]   count,
  input  logic               ge_watermark
);

  ocl_pkg::reg_sel_e  wr_sel;
  ocl_pkg::reg_sel_e  rd_sel;
  ocl_pkg::ocl_data_t hello_q;
  logic [LED_W-1:0]   vled_q;

  // Address decode
  function automatic ocl_pkg::reg_sel_e decode_addr(input ocl_pkg::ocl_addr_t addr);
    case (addr)
      ocl_pkg::ADDR_ID0:           return ocl_pkg::SEL_ID0;
      ocl_pkg::ADDR_ID1:           return ocl_pkg::SEL_ID1;
      ocl_pkg::ADDR_VERSION:       return ocl_pkg::SEL_VERSION;
      ocl_pkg::ADDR_HELLO_WORLD:   return ocl_pkg::SEL_HELLO_WORLD;
      ocl_pkg::ADDR_VLED:          return ocl_pkg::SEL_VLED;
      ocl_pkg::ADDR_CNT_CTRL:      return ocl_pkg::SEL_CNT_CTRL;
      ocl_pkg::ADDR_TICK_VALUE:    return ocl_pkg::SEL_TICK_VALUE;
      ocl_pkg::ADDR_CNT_LOAD:      return ocl_pkg::SEL_CNT_LOAD;
      ocl_pkg::ADDR_CNT_WATERMARK: return ocl_pkg::SEL_CNT_WATERMARK;
      ocl_pkg::ADDR_CNT_STATUS:    return ocl_pkg::SEL_CNT_STATUS;
      default:                     return ocl_pkg::SEL_NONE;
    endcase
  endfunction

  assign wr_sel = decode_addr(reg_wr_addr);
  assign rd_sel = decode_addr(reg_rd_addr);

  //------------------------------
  // Writable registers
  //------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q     <= '0;
      vled_q      <= '0;
      cnt_enable  <= 1'b0;
      cnt_oneshot <= 1'b0;
      cnt_clear   <= 1'b0;
      cnt_load    <= 1'b0;
      tick_value  <= '0;
      load_value  <= '0;
      watermark   <= '0;
    end else begin
      // LED shadow trails hello by one cycle
      vled_q    <= hello_q[LED_W-1:0];
      // Clear and load are single-cycle pulses
      cnt_clear <= 1'b0;
      cnt_load  <= 1'b0;
      if (reg_wr_en) begin
        case (wr_sel)
          ocl_pkg::SEL_HELLO_WORLD: hello_q <= reg_wr_data;
          ocl_pkg::SEL_CNT_CTRL: begin
            cnt_enable  <= reg_wr_data[ocl_pkg::CTRL_ENABLE_BIT];
            cnt_oneshot <= reg_wr_data[ocl_pkg::CTRL_ONESHOT_BIT];
            cnt_clear   <= reg_wr_data[ocl_pkg::CTRL_CLEAR_BIT];
            cnt_load    <= reg_wr_data[ocl_pkg::CTRL_LOAD_BIT];
          end
          ocl_pkg::SEL_TICK_VALUE:    tick_value <= reg_wr_data[TICK_W-1:0];
          ocl_pkg::SEL_CNT_LOAD:      load_value <= reg_wr_data[CNT_W-1:0];
          ocl_pkg::SEL_CNT_WATERMARK: watermark  <= reg_wr_data[CNT_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // LEDs masked by DIP switches
  assign status_vled = vled_q & status_vdip;

  //------------------------------
  // Read mux
  //------------------------------
  always_comb begin
    reg_rd_data = '0;
    case (rd_sel)
      ocl_pkg::SEL_HELLO_WORLD:
        reg_rd_data = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};
      ocl_pkg::SEL_VLED:          reg_rd_data = ocl_pkg::ocl_data_t'(vled_q);
      // Pulse bits always read back 0
      ocl_pkg::SEL_CNT_CTRL: begin
        reg_rd_data[ocl_pkg::CTRL_ENABLE_BIT]  = cnt_enable;
        reg_rd_data[ocl_pkg::CTRL_ONESHOT_BIT] = cnt_oneshot;
      end
      ocl_pkg::SEL_TICK_VALUE:    reg_rd_data = ocl_pkg::ocl_data_t'(tick_value);
      ocl_pkg::SEL_CNT_LOAD:      reg_rd_data = ocl_pkg::ocl_data_t'(load_value);
      ocl_pkg::SEL_CNT_WATERMARK: reg_rd_data = ocl_pkg::ocl_data_t'(watermark);
      ocl_pkg::SEL_CNT_STATUS: begin
        reg_rd_data[CNT_W-1:0]             = count;
        reg_rd_data[ocl_pkg::STATUS_GE_BIT] = ge_watermark;
      end
      ocl_pkg::SEL_ID0:           reg_rd_data = ocl_pkg::CL_ID0;
      ocl_pkg::SEL_ID1:           reg_rd_data = ocl_pkg::CL_ID1;
      ocl_pkg::SEL_VERSION:       reg_rd_data = ocl_pkg::CL_VERSION;
      default:                    reg_rd_data = ocl_pkg::UNIMPLEMENTED_VALUE;
    endcase
  end

endmodule

// File: hdl/ocl_pkg.sv
//------------------------------
// Host register bus definitions
//------------------------------
package ocl_pkg;

  // Bus widths
  localparam int OCL_ADDR_W = 32;
  localparam int OCL_DATA_W = 32;

  typedef logic [OCL_ADDR_W-1:0] ocl_addr_t;
  typedef logic [OCL_DATA_W-1:0] ocl_data_t;

  // AXI-Lite response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } ocl_resp_e;

  //------------------------------
  // Register map
  //------------------------------
  localparam ocl_addr_t ADDR_ID0           = 32'h0000_0000;
  localparam ocl_addr_t ADDR_ID1           = 32'h0000_0004;
  localparam ocl_addr_t ADDR_VERSION       = 32'h0000_0008;
  localparam ocl_addr_t ADDR_HELLO_WORLD   = 32'h0000_0500;
  localparam ocl_addr_t ADDR_VLED          = 32'h0000_0504;
  localparam ocl_addr_t ADDR_CNT_CTRL      = 32'h0000_0510;
  localparam ocl_addr_t ADDR_TICK_VALUE    = 32'h0000_0514;
  localparam ocl_addr_t ADDR_CNT_LOAD      = 32'h0000_0518;
  localparam ocl_addr_t ADDR_CNT_WATERMARK = 32'h0000_051C;
  localparam ocl_addr_t ADDR_CNT_STATUS    = 32'h0000_0520;

  // Counter control and status bit positions
  localparam int CTRL_ENABLE_BIT  = 0;
  localparam int CTRL_ONESHOT_BIT = 1;
  localparam int CTRL_CLEAR_BIT   = 2;
  localparam int CTRL_LOAD_BIT    = 3;
  localparam int STATUS_GE_BIT    = 16;

  // Read-only constants
  localparam ocl_data_t CL_ID0              = 32'hF000_1D0F;
  localparam ocl_data_t CL_ID1              = 32'h1D51_FEDD;
  localparam ocl_data_t CL_VERSION          = 32'hEEEE_EE00;
  localparam ocl_data_t UNIMPLEMENTED_VALUE = 32'hDEAD_BEEF;

  // Decoded register select
  typedef enum logic [3:0] {
    SEL_NONE, SEL_ID0, SEL_ID1, SEL_VERSION, SEL_HELLO_WORLD, SEL_VLED,
    SEL_CNT_CTRL, SEL_TICK_VALUE, SEL_CNT_LOAD, SEL_CNT_WATERMARK, SEL_CNT_STATUS
  } reg_sel_e;

  // Write channel FSM
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

endpackage

// File: hdl/ocl_read_channel.sv
//------------------------------
// Host read channel
//------------------------------
module ocl_read_channel (
  input  logic               clk_main_a0,
  input  logic               rst_main_n_sync,
  input  logic               arvalid,
  input  ocl_pkg::ocl_addr_t araddr,
  output logic               arready,
  output logic               rvalid,
  output ocl_pkg::ocl_data_t rdata,
  output ocl_pkg::ocl_resp_e rresp,
  input  logic               rready,
  output ocl_pkg::ocl_addr_t reg_rd_addr,
  input  ocl_pkg::ocl_data_t reg_rd_data
);

  logic               pending_q;
  logic               rvalid_q;
  ocl_pkg::ocl_addr_t addr_q;
  ocl_pkg::ocl_data_t rdata_q;

  // No new address while a read is pending or a response is held
  assign arready = !pending_q && !rvalid_q;

  // Control flags
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      pending_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      if (arvalid && arready) begin
        pending_q <= 1'b1;
      end else if (pending_q) begin
        pending_q <= 1'b0;
      end
      if (pending_q) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Address and sampled data
  always_ff @(posedge clk_main_a0) begin
    if (arvalid && arready) begin
      addr_q <= araddr;
    end
    // Sample register file one cycle after the address
    if (pending_q) begin
      rdata_q <= reg_rd_data;
    end
  end

  assign reg_rd_addr = addr_q;
  assign rvalid      = rvalid_q;
  assign rdata       = rdata_q;
  assign rresp       = ocl_pkg::RESP_OKAY;

  // Response held steady under back-pressure
  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("read response changed before rready");

endmodule

// File: hdl/ocl_write_channel.sv
//------------------------------
// Host write channel
//------------------------------
module ocl_write_channel (
  input  logic               clk_main_a0,
  input  logic               rst_main_n_sync,
  input  logic               awvalid,
  input  ocl_pkg::ocl_addr_t awaddr,
  output logic               awready,
  input  logic               wvalid,
  input  ocl_pkg::ocl_data_t wdata,
  output logic               wready,
  output logic               bvalid,
  output ocl_pkg::ocl_resp_e bresp,
  input  logic               bready,
  output logic               reg_wr_en,
  output ocl_pkg::ocl_addr_t reg_wr_addr,
  output ocl_pkg::ocl_data_t reg_wr_data
);

  ocl_pkg::wr_state_e state_q;
  ocl_pkg::wr_state_e state_d;
  ocl_pkg::ocl_addr_t addr_q;

  // Next state, one write in flight
  always_comb begin
    state_d = state_q;
    case (state_q)
      ocl_pkg::WR_IDLE: begin
        if (awvalid) begin
          state_d = ocl_pkg::WR_DATA;
        end
      end
      ocl_pkg::WR_DATA: begin
        if (wvalid) begin
          state_d = ocl_pkg::WR_RESP;
        end
      end
      ocl_pkg::WR_RESP: begin
        if (bready) begin
          state_d = ocl_pkg::WR_IDLE;
        end
      end
      default: state_d = ocl_pkg::WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      state_q <= ocl_pkg::WR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Address held for the data phase
  always_ff @(posedge clk_main_a0) begin
    if (awvalid && awready) begin
      addr_q <= awaddr;
    end
  end

  // Handshake outputs straight from state
  assign awready = (state_q == ocl_pkg::WR_IDLE);
  assign wready  = (state_q == ocl_pkg::WR_DATA);
  assign bvalid  = (state_q == ocl_pkg::WR_RESP);
  assign bresp   = ocl_pkg::RESP_OKAY;

  // Register strobe on the w transfer
  assign reg_wr_en   = wvalid && wready;
  assign reg_wr_addr = addr_q;
  assign reg_wr_data = wdata;

  // Response must wait for the host
  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  // Strobe only in the data phase and always followed by a response
  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    reg_wr_en |-> (state_q == ocl_pkg::WR_DATA) ##1 bvalid)
    else $error("register write strobe outside data phase");

endmodule

// File: hdl/tick_counter.sv
//------------------------------
// Prescaled event counter
//------------------------------
module tick_counter #(
  parameter int CNT_W  = 16,
  parameter int TICK_W = 8
) (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic              cnt_enable,
  input  logic              cnt_oneshot,
  input  logic              cnt_clear,
  input  logic              cnt_load,
  input  logic [TICK_W-1:0] tick_value,
  input  logic [CNT_W-1:0]  load_value,
  input  logic [CNT_W-1:0]  watermark,
  output logic [CNT_W-1:0]  count,
  output logic              ge_watermark
);

  logic [TICK_W-1:0] prescale_q;
  logic              tick;
  logic              at_max;

  // Wrap on reaching the tick value, also recovers if tick value drops
  assign tick   = (prescale_q >= tick_value);
  assign at_max = (count == {CNT_W{1'b1}});

  // Clear beats load, load beats counting
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync || cnt_clear) begin
      prescale_q <= '0;
      count      <= '0;
    end else if (cnt_load) begin
      count <= load_value;
    end else if (cnt_enable) begin
      prescale_q <= tick ? '0 : prescale_q + 1'b1;
      // One-shot saturates, otherwise free-running wrap
      if (tick && !(cnt_oneshot && at_max)) begin
        count <= count + 1'b1;
      end
    end
  end

  assign ge_watermark = (count >= watermark);

  // Prescaler bounded by tick value once it has settled
  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    cnt_enable && $past(cnt_enable) && $stable(tick_value) |-> prescale_q <= tick_value)
    else $error("prescaler above tick value");

endmodule

// File: testbench/tb_cl_hello_world.sv
//------------------------------
// Hello world endpoint testbench
//------------------------------
module tb_cl_hello_world;

  logic        clk_main_a0;
  logic        rst_main_n_sync;
  logic        awvalid;
  logic [31:0] awaddr;
  logic        awready;
  logic        wvalid;
  logic [31:0] wdata;
  logic        wready;
  logic        bvalid;
  logic [1:0]  bresp;
  logic        bready;
  logic        arvalid;
  logic [31:0] araddr;
  logic        arready;
  logic        rvalid;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rready;
  logic [15:0] status_vdip;
  logic [15:0] status_vled;

  // Scoreboard counts
  int checks;
  int errors;
  int test_errors;

  // Model state
  logic [31:0] exp_hello;
  logic [15:0] exp_wm;

  cl_hello_world uut (
    .clk_main_a0, .rst_main_n_sync, .awvalid, .awaddr, .awready, .wvalid, .wdata,
    .wready, .bvalid, .bresp, .bready, .arvalid, .araddr, .arready, .rvalid,
    .rdata, .rresp, .rready, .status_vdip, .status_vled
  );

  always #4 clk_main_a0 = ~clk_main_a0;

  function automatic logic [31:0] byte_reverse(input logic [31:0] value);
    logic [31:0] swapped;
    for (int i = 0; i < 4; i++) begin
      swapped[8*i +: 8] = value[8*(3-i) +: 8];
    end
    return swapped;
  endfunction

  // Addresses that the register map decodes
  function automatic bit is_mapped(input logic [31:0] addr);
    return addr inside {ocl_pkg::ADDR_ID0, ocl_pkg::ADDR_ID1, ocl_pkg::ADDR_VERSION,
      ocl_pkg::ADDR_HELLO_WORLD, ocl_pkg::ADDR_VLED, ocl_pkg::ADDR_CNT_CTRL,
      ocl_pkg::ADDR_TICK_VALUE, ocl_pkg::ADDR_CNT_LOAD, ocl_pkg::ADDR_CNT_WATERMARK,
      ocl_pkg::ADDR_CNT_STATUS};
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at time %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout after 100 cycles waiting for %s", what);
    $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic finish_test(input int num, input string name);
    $display("Test %0d %s finished with %0d errors", num, name, errors - test_errors);
    test_errors = errors;
  endtask

  //------------------------------
  // Bus tasks
  //------------------------------
  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                           input int hold);
    int cycles;
    @(negedge clk_main_a0);
    awvalid = 1'b1;
    awaddr  = addr;
    bready  = (hold == 0);
    cycles  = 0;
    while (!awready && cycles < 100) begin
      @(negedge clk_main_a0);
      cycles++;
    end
    if (cycles >= 100) report_timeout("awready");
    // Address taken on the next rising edge
    @(negedge clk_main_a0);
    awvalid = 1'b0;
    wvalid  = 1'b1;
    wdata   = data;
    cycles  = 0;
    while (!wready && cycles < 100) begin
      @(negedge clk_main_a0);
      cycles++;
    end
    if (cycles >= 100) report_timeout("wready");
    @(negedge clk_main_a0);
    wvalid = 1'b0;
    cycles = 0;
    while (!bvalid && cycles < 100) begin
      @(negedge clk_main_a0);
      cycles++;
    end
    if (cycles >= 100) report_timeout("bvalid");
    check_value("bresp", bresp, ocl_pkg::RESP_OKAY);
    // Held response blocks the next address
    repeat (hold) begin
      @(negedge clk_main_a0);
      check_value("bvalid under back-pressure", bvalid, 1'b1);
      check_value("awready under back-pressure", awready, 1'b0);
    end
    bready = 1'b1;
    @(negedge clk_main_a0);
  endtask

  task automatic read_reg(input logic [31:0] addr, input int hold,
                          output logic [31:0] data);
    int cycles;
    @(negedge clk_main_a0);
    arvalid = 1'b1;
    araddr  = addr;
    rready  = (hold == 0);
    cycles  = 0;
    while (!arready && cycles < 100) begin
      @(negedge clk_main_a0);
      cycles++;
    end
    if (cycles >= 100) report_timeout("arready");
    @(negedge clk_main_a0);
    arvalid = 1'b0;
    cycles  = 0;
    while (!rvalid && cycles < 100) begin
      @(negedge clk_main_a0);
      cycles++;
    end
    if (cycles >= 100) report_timeout("rvalid");
    data = rdata;
    check_value("rresp", rresp, ocl_pkg::RESP_OKAY);
    // Data frozen, no new address while held
    repeat (hold) begin
      @(negedge clk_main_a0);
      check_value("rdata under back-pressure", rdata, data);
      check_value("arready under back-pressure", arready, 1'b0);
    end
    rready = 1'b1;
    @(negedge clk_main_a0);
  endtask

  //------------------------------
  // Test sequence
  //------------------------------
  initial begin
    logic [31:0] rd;
    logic [31:0] addr;
    logic [15:0] val;
    void'($urandom(32'hf8c6fd12));
    clk_main_a0 = 1'b0;
    rst_main_n_sync = 1'b0;
    {awvalid, wvalid, bready, arvalid, rready} = '0;
    awaddr = '0;
    wdata = '0;
    araddr = '0;
    // All switches on, so the LED output shows the shadow register
    status_vdip = '1;
    checks = 0;
    errors = 0;
    test_errors = 0;
    exp_hello = '0;
    exp_wm = '0;
    repeat (2) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;

    // Reset values and constants
    @(negedge clk_main_a0);
    check_value("ready flags after reset", {awready, arready}, 2'b11);
    check_value("busy flags after reset", {wready, bvalid, rvalid}, 3'b000);
    check_value("status_vled after reset", status_vled, 16'h0);
    read_reg(ocl_pkg::ADDR_ID0, 0, rd);
    check_value("ID0", rd, ocl_pkg::CL_ID0);
    read_reg(ocl_pkg::ADDR_ID1, 0, rd);
    check_value("ID1", rd, ocl_pkg::CL_ID1);
    read_reg(ocl_pkg::ADDR_VERSION, 0, rd);
    check_value("VERSION", rd, ocl_pkg::CL_VERSION);
    read_reg(ocl_pkg::ADDR_HELLO_WORLD, 0, rd);
    check_value("HELLO_WORLD after reset", rd, 32'h0);
    repeat (8) begin
      addr = $urandom();
      while (is_mapped(addr)) addr = $urandom();
      read_reg(addr, 0, rd);
      check_value("unmapped read", rd, ocl_pkg::UNIMPLEMENTED_VALUE);
    end
    finish_test(1, "reset and constants");

    // Hello byte reversal
    repeat (20) begin
      exp_hello = $urandom();
      write_reg(ocl_pkg::ADDR_HELLO_WORLD, exp_hello, 0);
      read_reg(ocl_pkg::ADDR_HELLO_WORLD, 0, rd);
      check_value("HELLO_WORLD readback", rd, byte_reverse(exp_hello));
    end
    finish_test(2, "hello byte reversal");

    // LED shadow and DIP mask
    repeat (10) begin
      exp_hello = $urandom();
      write_reg(ocl_pkg::ADDR_HELLO_WORLD, exp_hello, 0);
      read_reg(ocl_pkg::ADDR_VLED, 0, rd);
      check_value("VLED readback", rd, {16'h0, exp_hello[15:0]});
      status_vdip = $urandom();
      @(negedge clk_main_a0);
      check_value("status_vled", status_vled, exp_hello[15:0] & status_vdip);
    end
    finish_test(3, "LED shadow");

    // Back-pressure on both response channels
    repeat (10) begin
      exp_hello = $urandom();
      write_reg(ocl_pkg::ADDR_HELLO_WORLD, exp_hello, $urandom_range(10, 0));
      read_reg(ocl_pkg::ADDR_HELLO_WORLD, $urandom_range(10, 0), rd);
      check_value("HELLO_WORLD after hold", rd, byte_reverse(exp_hello));
    end
    finish_test(4, "back-pressure");

    // Load with counter stopped
    val = $urandom();
    exp_wm = $urandom();
    write_reg(ocl_pkg::ADDR_CNT_LOAD, {16'h0, val}, 0);
    write_reg(ocl_pkg::ADDR_CNT_WATERMARK, {16'h0, exp_wm}, 0);
    write_reg(ocl_pkg::ADDR_CNT_CTRL, 32'h8, 0);
    read_reg(ocl_pkg::ADDR_CNT_STATUS, 0, rd);
    check_value("CNT_STATUS after load", rd, {15'h0, val >= exp_wm, val});
    read_reg(ocl_pkg::ADDR_CNT_CTRL, 0, rd);
    check_value("CNT_CTRL pulse bits", rd, 32'h0);
    finish_test(5, "counter load");

    // One-shot saturation then clear
    write_reg(ocl_pkg::ADDR_TICK_VALUE, 32'h0, 0);
    write_reg(ocl_pkg::ADDR_CNT_LOAD, 32'hFFFE, 0);
    // One-shot with load pulse, then enable
    write_reg(ocl_pkg::ADDR_CNT_CTRL, 32'hA, 0);
    write_reg(ocl_pkg::ADDR_CNT_CTRL, 32'h3, 0);
    repeat (20) @(negedge clk_main_a0);
    read_reg(ocl_pkg::ADDR_CNT_STATUS, 0, rd);
    check_value("count saturated", rd[15:0], 16'hFFFF);
    exp_wm = 16'h0;
    write_reg(ocl_pkg::ADDR_CNT_WATERMARK, 32'h0, 0);
    write_reg(ocl_pkg::ADDR_CNT_CTRL, 32'h4, 0);
    read_reg(ocl_pkg::ADDR_CNT_STATUS, 0, rd);
    check_value("CNT_STATUS after clear", rd, {15'h0, 16'h0 >= exp_wm, 16'h0});
    finish_test(6, "one-shot and clear");

    $display("Checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
